/* tb.f */
+incdir+verif
src/rn_pkg.sv
src/select_latest_1bit.sv
src/rn_free_list.sv
src/rn_map_table.sv
src/rn_inflight_list.sv
src/rn_dispatch_stage.sv
src/rn_rename_top.sv
verif/tb_rn_rename.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing -f tb.f --top-module tb_rn_rename -o tb_rn_rename \
  && ./obj_dir/tb_rn_rename | tee /dev/stderr | grep -q "Test passed" \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }

/* verif/rn_ref_model.svh */
`ifndef RN_REF_MODEL_SVH
`define RN_REF_MODEL_SVH

// Model state advanced once per cycle ahead of the clock edge
logic [RNID_W-1:0]    m_map [ARCH_SIZE];
logic [RNID_SIZE-1:0] m_ready;
logic [RNID_W-1:0]    m_free_q [$];
logic [RNID_W-1:0]    m_old_q [$];  // Old rnids waiting for commit
logic [RNID_W-1:0]    m_wb_q [$];   // Allocated and not yet written back
int                   m_credits;
logic [DISP-1:0]      m_alloc;
logic [RNID_W-1:0]    m_new [DISP];

// Expected dispatch group
logic [DISP-1:0]      e_valid;
logic [RNID_W-1:0]    e_rs1 [DISP];
logic [RNID_W-1:0]    e_rs2 [DISP];
logic [DISP-1:0]      e_rs1_rdy;
logic [DISP-1:0]      e_rs2_rdy;
logic [RNID_W-1:0]    e_rd [DISP];
logic [RNID_W-1:0]    e_old [DISP];
logic [DISP-1:0]      e_rd_en;

task automatic model_reset();
  m_free_q.delete();
  m_old_q.delete();
  m_wb_q.delete();
  for (int i = 0; i < ARCH_SIZE; i++) begin
    m_map[i] = RNID_W'(i);
  end
  for (int i = ARCH_SIZE; i < RNID_SIZE; i++) begin
    m_free_q.push_back(RNID_W'(i));
  end
  m_ready   = '1;
  m_credits = CREDITS;
  e_valid   = '0;
endtask

function automatic logic model_in_ready();
  return (m_free_q.size() >= 2) && (m_credits >= 2);
endfunction

// x0, then writeback, then allocation, then the stored bit
function automatic logic predict_ready(logic [RNID_W-1:0] rn);
  if (rn == '0) return 1'b1;
  for (int w = 0; w < WBN; w++) begin
    if (wb_valid[w] && (wb_rnid[w] == rn)) return 1'b1;
  end
  for (int l = 0; l < DISP; l++) begin
    if (m_alloc[l] && (m_new[l] == rn)) return 1'b0;
  end
  return m_ready[rn];
endfunction

function automatic void drop_pending_wb(logic [RNID_W-1:0] rn);
  for (int i = 0; i < m_wb_q.size(); i++) begin
    if (m_wb_q[i] == rn) begin
      m_wb_q.delete(i);
      return;
    end
  end
endfunction

task automatic model_step(input bit accept);
  int k;
  k = 0;
  for (int l = 0; l < DISP; l++) begin
    m_alloc[l] = accept && lane_valid[l] && rd_en[l] && (rd[l] != '0);
    m_new[l]   = '0;
    if (m_alloc[l]) begin
      m_new[l] = m_free_q[k];
      k++;
    end
  end
  for (int l = 0; l < DISP; l++) begin
    e_rs1[l] = m_map[rs1[l]];
    e_rs2[l] = m_map[rs2[l]];
    e_old[l] = m_map[rd[l]];
    for (int j = 0; j < l; j++) begin  // Younger producer in the group wins
      if (m_alloc[j] && (rd[j] == rs1[l])) e_rs1[l] = m_new[j];
      if (m_alloc[j] && (rd[j] == rs2[l])) e_rs2[l] = m_new[j];
      if (m_alloc[j] && (rd[j] == rd[l])) e_old[l] = m_new[j];
    end
    e_rs1_rdy[l] = predict_ready(e_rs1[l]);
    e_rs2_rdy[l] = predict_ready(e_rs2[l]);
    e_rd_en[l]   = m_alloc[l];
    e_rd[l]      = m_new[l];
  end
  e_valid = accept ? lane_valid : '0;
  for (int l = 0; l < DISP; l++) begin
    if (m_alloc[l]) begin
      m_free_q.delete(0);
      m_old_q.push_back(e_old[l]);
      m_wb_q.push_back(m_new[l]);
      m_map[rd[l]] = m_new[l];
    end else begin
      e_old[l] = '0;
    end
  end
  for (int w = 0; w < WBN; w++) begin
    if (wb_valid[w]) m_ready[wb_rnid[w]] = 1'b1;
  end
  for (int l = 0; l < DISP; l++) begin
    if (m_alloc[l]) m_ready[m_new[l]] = 1'b0;
    if (commit_valid[l]) m_free_q.push_back(commit_rnid[l]);
  end
  m_credits = m_credits - $countones(e_valid) + $countones(credit_ret);
endtask

`endif

/* verif/tb_rn_rename.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_rn_rename;

  localparam int DISP           = rn_pkg::DISP_SIZE;
  localparam int WBN            = rn_pkg::WB_SIZE;
  localparam int ARCH_W         = rn_pkg::ARCH_W;
  localparam int ARCH_SIZE      = rn_pkg::ARCH_SIZE;
  localparam int RNID_W         = rn_pkg::RNID_W;
  localparam int RNID_SIZE      = rn_pkg::RNID_SIZE;
  localparam int CREDITS        = 4;
  localparam int N_CYCLES       = 2000;
  localparam int TIMEOUT_CYCLES = 2 * N_CYCLES + 50;

  logic              i_clk;
  logic              i_reset_n;
  logic              in_valid;
  logic [DISP-1:0]   lane_valid;
  logic [ARCH_W-1:0] rs1 [DISP];
  logic [ARCH_W-1:0] rs2 [DISP];
  logic [ARCH_W-1:0] rd [DISP];
  logic [DISP-1:0]   rd_en;
  logic [WBN-1:0]    wb_valid;
  logic [RNID_W-1:0] wb_rnid [WBN];
  logic [DISP-1:0]   commit_valid;
  logic [RNID_W-1:0] commit_rnid [DISP];
  logic [DISP-1:0]   credit_ret;

  logic              in_ready;
  logic [DISP-1:0]   out_valid;
  logic [RNID_W-1:0] out_rs1_rnid [DISP];
  logic [RNID_W-1:0] out_rs2_rnid [DISP];
  logic [DISP-1:0]   out_rs1_ready;
  logic [DISP-1:0]   out_rs2_ready;
  logic [RNID_W-1:0] out_rd_rnid [DISP];
  logic [RNID_W-1:0] out_old_rnid [DISP];
  logic [DISP-1:0]   out_rd_en;

  int cycle_cnt = 0;
  int outstanding = 0;  // Lanes sent and not yet credited back
  int sent_lanes = 0;
  int stall_cycles = 0;

  `include "rn_ref_model.svh"

  rn_rename_top #(
    .CREDITS (CREDITS)
  ) dut (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_in_valid      (in_valid),
    .o_in_ready      (in_ready),
    .i_lane_valid    (lane_valid),
    .i_rs1           (rs1),
    .i_rs2           (rs2),
    .i_rd            (rd),
    .i_rd_en         (rd_en),
    .i_wb_valid      (wb_valid),
    .i_wb_rnid       (wb_rnid),
    .i_commit_valid  (commit_valid),
    .i_commit_rnid   (commit_rnid),
    .o_out_valid     (out_valid),
    .o_out_rs1_rnid  (out_rs1_rnid),
    .o_out_rs2_rnid  (out_rs2_rnid),
    .o_out_rs1_ready (out_rs1_ready),
    .o_out_rs2_ready (out_rs2_ready),
    .o_out_rd_rnid   (out_rd_rnid),
    .o_out_old_rnid  (out_old_rnid),
    .o_out_rd_en     (out_rd_en),
    .i_credit_ret    (credit_ret)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: simulation still running after %0d cycles", cycle_cnt);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Mostly a few low registers so groups collide often
  function automatic logic [ARCH_W-1:0] rand_reg();
    if (($urandom % 4) != 0) return ARCH_W'($urandom % 8);
    return ARCH_W'($urandom);
  endfunction

  task automatic check_outputs();
    compare_value("o_out_valid", 32'(out_valid), 32'(e_valid));
    sent_lanes  = sent_lanes + $countones(out_valid);
    outstanding = outstanding + $countones(out_valid) - $countones(credit_ret);
    if (outstanding > CREDITS) begin
      $display("Issue queue holds %0d lanes but only %0d credits exist", outstanding, CREDITS);
      $display("Test failed");
      $fatal(1);
    end
    for (int l = 0; l < DISP; l++) begin
      if (e_valid[l]) begin
        compare_value($sformatf("o_out_rs1_rnid[%0d]", l), 32'(out_rs1_rnid[l]), 32'(e_rs1[l]));
        compare_value($sformatf("o_out_rs2_rnid[%0d]", l), 32'(out_rs2_rnid[l]), 32'(e_rs2[l]));
        compare_value($sformatf("o_out_rs1_ready[%0d]", l), 32'(out_rs1_ready[l]),
                      32'(e_rs1_rdy[l]));
        compare_value($sformatf("o_out_rs2_ready[%0d]", l), 32'(out_rs2_ready[l]),
                      32'(e_rs2_rdy[l]));
        compare_value($sformatf("o_out_rd_en[%0d]", l), 32'(out_rd_en[l]), 32'(e_rd_en[l]));
        compare_value($sformatf("o_out_rd_rnid[%0d]", l), 32'(out_rd_rnid[l]), 32'(e_rd[l]));
        compare_value($sformatf("o_out_old_rnid[%0d]", l), 32'(out_old_rnid[l]), 32'(e_old[l]));
      end
    end
  endtask

  task automatic drive_inputs(input bit keep_group, input bit hold_credits,
                              input bit hold_commits);
    int idx;
    int owed;
    if (!keep_group) begin  // A stalled group stays on the bus
      in_valid   = ($urandom % 4) != 0;
      lane_valid = DISP'($urandom);
      rd_en      = DISP'($urandom);
      for (int l = 0; l < DISP; l++) begin
        rs1[l] = rand_reg();
        rs2[l] = rand_reg();
        rd[l]  = rand_reg();
      end
    end
    for (int w = 0; w < WBN; w++) begin
      wb_valid[w] = 1'b0;
      wb_rnid[w]  = RNID_W'($urandom);
      if ((m_wb_q.size() > 0) && (($urandom % 3) == 0)) begin
        idx = int'($urandom % m_wb_q.size());
        wb_rnid[w]  = m_wb_q[idx];
        wb_valid[w] = 1'b1;
        m_wb_q.delete(idx);
      end
    end
    for (int l = 0; l < DISP; l++) begin
      commit_valid[l] = 1'b0;
      commit_rnid[l]  = RNID_W'($urandom);
      if (!hold_commits && (m_old_q.size() > 0) && (($urandom % 2) == 0)) begin
        commit_rnid[l]  = m_old_q.pop_front();
        commit_valid[l] = 1'b1;
        drop_pending_wb(commit_rnid[l]);
      end
    end
    owed = CREDITS - m_credits;
    for (int l = 0; l < DISP; l++) begin
      credit_ret[l] = 1'b0;
      if (!hold_credits && (owed > 0) && (($urandom % 2) == 0)) begin
        credit_ret[l] = 1'b1;
        owed--;
      end
    end
  endtask

  initial begin
    bit accepted;
    bit held;
    bit hold_credits;
    bit hold_commits;
    void'($urandom(94574));
    i_reset_n    = 1'b0;
    in_valid     = 1'b0;
    lane_valid   = '0;
    rd_en        = '0;
    wb_valid     = '0;
    commit_valid = '0;
    credit_ret   = '0;
    for (int l = 0; l < DISP; l++) begin
      rs1[l]         = '0;
      rs2[l]         = '0;
      rd[l]          = '0;
      commit_rnid[l] = '0;
    end
    for (int w = 0; w < WBN; w++) begin
      wb_rnid[w] = '0;
    end
    repeat (3) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    model_reset();
    compare_value("o_in_ready", 32'(in_ready), 32'd1);
    compare_value("o_out_valid", 32'(out_valid), 32'd0);
    held = 1'b0;
    for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
      hold_credits = (cyc >= 600) && (cyc < 800);    // Starve the dispatch credits
      hold_commits = (cyc >= 1200) && (cyc < 1500);  // Drain the free list
      @(posedge i_clk);
      #1;
      check_outputs();
      drive_inputs(held, hold_credits, hold_commits);
      @(negedge i_clk);
      compare_value("o_in_ready", 32'(in_ready), 32'(model_in_ready()));
      if (!in_ready) stall_cycles++;
      accepted = in_valid && model_in_ready();
      held     = in_valid && !accepted;
      model_step(accepted);
    end
    @(posedge i_clk);
    #1;
    check_outputs();
    if ((sent_lanes < 500) || (stall_cycles == 0)) begin
      $display("Too little traffic: %0d lanes sent, %0d stall cycles", sent_lanes, stall_cycles);
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src/rn_rename_top.sv */
`default_nettype none
`timescale 1ns/1ns

module rn_rename_top #(
  parameter int CREDITS = 4
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  // Upstream group
  input  logic                             i_in_valid,
  output logic                             o_in_ready,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_lane_valid,
  input  logic [rn_pkg::ARCH_W-1:0]        i_rs1 [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::ARCH_W-1:0]        i_rs2 [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::ARCH_W-1:0]        i_rd [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_rd_en,
  // Writeback and commit
  input  logic [rn_pkg::WB_SIZE-1:0]       i_wb_valid,
  input  logic [rn_pkg::RNID_W-1:0]        i_wb_rnid [rn_pkg::WB_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_commit_valid,
  input  logic [rn_pkg::RNID_W-1:0]        i_commit_rnid [rn_pkg::DISP_SIZE],
  // Issue queue side
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_valid,
  output logic [rn_pkg::RNID_W-1:0]        o_out_rs1_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_out_rs2_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rs1_ready,
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rs2_ready,
  output logic [rn_pkg::RNID_W-1:0]        o_out_rd_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_out_old_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rd_en,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_credit_ret
);

  logic                             w_accept;
  logic                             w_has_two_free;
  logic                             w_has_two_credits;
  logic [rn_pkg::DISP_SIZE-1:0]     w_alloc;
  logic [rn_pkg::DISP_SIZE-1:0]     w_alloc_acc;
  logic [rn_pkg::RNID_W-1:0]        w_new_rnid [rn_pkg::DISP_SIZE];
  logic [rn_pkg::RNID_W-1:0]        w_rs1_rnid [rn_pkg::DISP_SIZE];
  logic [rn_pkg::RNID_W-1:0]        w_rs2_rnid [rn_pkg::DISP_SIZE];
  logic [rn_pkg::RNID_W-1:0]        w_old_rnid [rn_pkg::DISP_SIZE];
  logic [rn_pkg::RNID_W-1:0]        w_lookup_rnid [rn_pkg::LOOKUP_SIZE];
  logic [rn_pkg::LOOKUP_SIZE-1:0]   w_src_ready;
  logic [rn_pkg::DISP_SIZE-1:0]     w_rs1_ready;
  logic [rn_pkg::DISP_SIZE-1:0]     w_rs2_ready;

  // Worst case a group needs two rnids and two credits
  assign o_in_ready  = w_has_two_free & w_has_two_credits;
  assign w_accept    = i_in_valid & o_in_ready;
  assign w_alloc_acc = w_alloc & {rn_pkg::DISP_SIZE{w_accept}};

  generate
    for (genvar l = 0; l < rn_pkg::DISP_SIZE; l++) begin : g_lane
      assign w_lookup_rnid[2*l]   = w_rs1_rnid[l];
      assign w_lookup_rnid[2*l+1] = w_rs2_rnid[l];
      assign w_rs1_ready[l]       = w_src_ready[2*l];
      assign w_rs2_ready[l]       = w_src_ready[2*l+1];
    end
  endgenerate

  rn_free_list u_free_list (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_pop       (w_alloc_acc),
    .i_push      (i_commit_valid),
    .i_push_rnid (i_commit_rnid),
    .o_pop_rnid  (w_new_rnid),
    .o_has_two   (w_has_two_free)
  );

  rn_map_table u_map_table (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_accept     (w_accept),
    .i_lane_valid (i_lane_valid),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rd         (i_rd),
    .i_rd_en      (i_rd_en),
    .i_new_rnid   (w_new_rnid),
    .o_rs1_rnid   (w_rs1_rnid),
    .o_rs2_rnid   (w_rs2_rnid),
    .o_old_rnid   (w_old_rnid),
    .o_alloc      (w_alloc)
  );

  rn_inflight_list #(
    .REG_KIND (rn_pkg::GPR)
  ) u_inflight_list (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rnid        (w_lookup_rnid),
    .i_alloc_valid (w_alloc_acc),
    .i_alloc_rnid  (w_new_rnid),
    .i_wb_valid    (i_wb_valid),
    .i_wb_rnid     (i_wb_rnid),
    .o_valids      (w_src_ready)
  );

  rn_dispatch_stage #(
    .CREDITS (CREDITS)
  ) u_dispatch_stage (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_accept          (w_accept),
    .i_lane_valid      (i_lane_valid),
    .i_rs1_rnid        (w_rs1_rnid),
    .i_rs2_rnid        (w_rs2_rnid),
    .i_rs1_ready       (w_rs1_ready),
    .i_rs2_ready       (w_rs2_ready),
    .i_rd_rnid         (w_new_rnid),
    .i_old_rnid        (w_old_rnid),
    .i_rd_en           (w_alloc),
    .i_credit_ret      (i_credit_ret),
    .o_has_two_credits (w_has_two_credits),
    .o_out_valid       (o_out_valid),
    .o_out_rs1_rnid    (o_out_rs1_rnid),
    .o_out_rs2_rnid    (o_out_rs2_rnid),
    .o_out_rs1_ready   (o_out_rs1_ready),
    .o_out_rs2_ready   (o_out_rs2_ready),
    .o_out_rd_rnid     (o_out_rd_rnid),
    .o_out_old_rnid    (o_out_old_rnid),
    .o_out_rd_en       (o_out_rd_en)
  );

endmodule

`default_nettype wire

/* src/rn_dispatch_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module rn_dispatch_stage #(
  parameter int CREDITS = 4
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_accept,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_lane_valid,
  input  logic [rn_pkg::RNID_W-1:0]        i_rs1_rnid [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::RNID_W-1:0]        i_rs2_rnid [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_rs1_ready,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_rs2_ready,
  input  logic [rn_pkg::RNID_W-1:0]        i_rd_rnid [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::RNID_W-1:0]        i_old_rnid [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_rd_en,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_credit_ret,
  output logic                             o_has_two_credits,
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_valid,
  output logic [rn_pkg::RNID_W-1:0]        o_out_rs1_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_out_rs2_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rs1_ready,
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rs2_ready,
  output logic [rn_pkg::RNID_W-1:0]        o_out_rd_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_out_old_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::DISP_SIZE-1:0]     o_out_rd_en
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] r_credits;
  logic [CNT_W-1:0] w_sent;
  logic [CNT_W-1:0] w_returned;

  always_comb begin
    w_sent     = '0;
    w_returned = '0;
    for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
      w_sent     = w_sent + CNT_W'(i_accept & i_lane_valid[l]);
      w_returned = w_returned + CNT_W'(i_credit_ret[l]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits   <= CNT_W'(CREDITS);
      o_out_valid <= '0;
    end else begin
      r_credits   <= r_credits - w_sent + w_returned;
      o_out_valid <= i_lane_valid & {rn_pkg::DISP_SIZE{i_accept}};  // One cycle only
    end
  end

  // Unused destination fields go out as zero
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
        o_out_rs1_rnid[l] <= i_rs1_rnid[l];
        o_out_rs2_rnid[l] <= i_rs2_rnid[l];
        o_out_rd_rnid[l]  <= i_rd_en[l] ? i_rd_rnid[l] : '0;
        o_out_old_rnid[l] <= i_rd_en[l] ? i_old_rnid[l] : '0;
      end
      o_out_rs1_ready <= i_rs1_ready;
      o_out_rs2_ready <= i_rs2_ready;
      o_out_rd_en     <= i_rd_en;
    end
  end

  assign o_has_two_credits = (r_credits >= CNT_W'(2));

endmodule

`default_nettype wire

/* src/rn_inflight_list.sv */
`default_nettype none
`timescale 1ns/1ns

module rn_inflight_list #(
  parameter rn_pkg::reg_kind_t REG_KIND = rn_pkg::GPR
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic [rn_pkg::RNID_W-1:0]        i_rnid [rn_pkg::LOOKUP_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_alloc_valid,
  input  logic [rn_pkg::RNID_W-1:0]        i_alloc_rnid [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::WB_SIZE-1:0]       i_wb_valid,
  input  logic [rn_pkg::RNID_W-1:0]        i_wb_rnid [rn_pkg::WB_SIZE],
  output logic [rn_pkg::LOOKUP_SIZE-1:0]   o_valids
);

  logic [rn_pkg::RNID_SIZE-1:0] r_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      for (int w = 0; w < rn_pkg::WB_SIZE; w++) begin
        if (i_wb_valid[w]) begin
          r_ready[i_wb_rnid[w]] <= 1'b1;
        end
      end
      // Applied after writeback so allocation wins on a clash
      for (int a = 0; a < rn_pkg::DISP_SIZE; a++) begin
        if (i_alloc_valid[a]) begin
          r_ready[i_alloc_rnid[a]] <= 1'b0;
        end
      end
    end
  end

  generate
    for (genvar k = 0; k < rn_pkg::LOOKUP_SIZE; k++) begin : g_lookup
      logic w_is_x0;
      logic w_wb_hit;
      logic w_wb_data;
      logic w_alloc_hit;
      logic w_alloc_data;

      // A fresh allocation reads as not ready
      select_latest_1bit #(
        .SEL_WIDTH (rn_pkg::DISP_SIZE),
        .KEY_WIDTH (rn_pkg::RNID_W)
      ) u_sel_alloc (
        .i_cmp_key (i_rnid[k]),
        .i_valid   (i_alloc_valid),
        .i_keys    (i_alloc_rnid),
        .i_data    ({rn_pkg::DISP_SIZE{1'b0}}),
        .o_valid   (w_alloc_hit),
        .o_data    (w_alloc_data)
      );

      select_latest_1bit #(
        .SEL_WIDTH (rn_pkg::WB_SIZE),
        .KEY_WIDTH (rn_pkg::RNID_W)
      ) u_sel_wb (
        .i_cmp_key (i_rnid[k]),
        .i_valid   (i_wb_valid),
        .i_keys    (i_wb_rnid),
        .i_data    ({rn_pkg::WB_SIZE{1'b1}}),
        .o_valid   (w_wb_hit),
        .o_data    (w_wb_data)
      );

      assign w_is_x0 = (REG_KIND == rn_pkg::GPR) && (i_rnid[k] == '0);

      assign o_valids[k] = w_is_x0     ? 1'b1 :
                           w_wb_hit    ? w_wb_data :
                           w_alloc_hit ? w_alloc_data :
                           r_ready[i_rnid[k]];
    end
  endgenerate

endmodule

`default_nettype wire

/* src/rn_map_table.sv */
`default_nettype none
`timescale 1ns/1ns

module rn_map_table (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_accept,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_lane_valid,
  input  logic [rn_pkg::ARCH_W-1:0]        i_rs1 [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::ARCH_W-1:0]        i_rs2 [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::ARCH_W-1:0]        i_rd [rn_pkg::DISP_SIZE],
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_rd_en,
  input  logic [rn_pkg::RNID_W-1:0]        i_new_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_rs1_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_rs2_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_old_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::DISP_SIZE-1:0]     o_alloc
);

  logic [rn_pkg::RNID_W-1:0] r_map [rn_pkg::ARCH_SIZE];

  // x0 is never renamed
  always_comb begin
    for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
      o_alloc[l] = i_lane_valid[l] & i_rd_en[l] & (i_rd[l] != '0);
    end
  end

  always_comb begin
    for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
      o_rs1_rnid[l] = r_map[i_rs1[l]];
      o_rs2_rnid[l] = r_map[i_rs2[l]];
      o_old_rnid[l] = r_map[i_rd[l]];
      // Youngest older lane in the group wins the bypass
      for (int j = 0; j < l; j++) begin
        if (o_alloc[j] && (i_rd[j] == i_rs1[l])) begin
          o_rs1_rnid[l] = i_new_rnid[j];
        end
        if (o_alloc[j] && (i_rd[j] == i_rs2[l])) begin
          o_rs2_rnid[l] = i_new_rnid[j];
        end
        if (o_alloc[j] && (i_rd[j] == i_rd[l])) begin
          o_old_rnid[l] = i_new_rnid[j];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < rn_pkg::ARCH_SIZE; i++) begin
        r_map[i] <= rn_pkg::RNID_W'(i);  // Identity mapping
      end
    end else if (i_accept) begin
      for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
        if (o_alloc[l]) begin
          r_map[i_rd[l]] <= i_new_rnid[l];  // Later lane overwrites
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/rn_free_list.sv */
`default_nettype none
`timescale 1ns/1ns

module rn_free_list (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_pop,
  input  logic [rn_pkg::DISP_SIZE-1:0]     i_push,
  input  logic [rn_pkg::RNID_W-1:0]        i_push_rnid [rn_pkg::DISP_SIZE],
  output logic [rn_pkg::RNID_W-1:0]        o_pop_rnid [rn_pkg::DISP_SIZE],
  output logic                             o_has_two
);

  localparam int CNT_W = rn_pkg::RNID_W + 1;
  localparam int INIT_FREE = rn_pkg::RNID_SIZE - rn_pkg::ARCH_SIZE;

  logic [rn_pkg::RNID_W-1:0] r_mem [rn_pkg::RNID_SIZE];
  logic [rn_pkg::RNID_W-1:0] r_head;
  logic [rn_pkg::RNID_W-1:0] r_tail;
  logic [CNT_W-1:0]          r_count;

  logic [CNT_W-1:0]          w_pop_cnt;
  logic [CNT_W-1:0]          w_push_cnt;
  logic [rn_pkg::RNID_W-1:0] w_pop_idx [rn_pkg::DISP_SIZE];
  logic [rn_pkg::RNID_W-1:0] w_push_idx [rn_pkg::DISP_SIZE];

  // Each lane takes the slot after those used by earlier lanes
  always_comb begin
    w_pop_cnt  = '0;
    w_push_cnt = '0;
    for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
      w_pop_idx[l]  = r_head + rn_pkg::RNID_W'(w_pop_cnt);  // Wraps at RNID_SIZE
      w_push_idx[l] = r_tail + rn_pkg::RNID_W'(w_push_cnt);
      o_pop_rnid[l] = r_mem[w_pop_idx[l]];
      w_pop_cnt     = w_pop_cnt + CNT_W'(i_pop[l]);
      w_push_cnt    = w_push_cnt + CNT_W'(i_push[l]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < rn_pkg::RNID_SIZE; i++) begin
        r_mem[i] <= rn_pkg::RNID_W'(i + rn_pkg::ARCH_SIZE);  // Upper half is don't care
      end
      r_head  <= '0;
      r_tail  <= rn_pkg::RNID_W'(INIT_FREE);
      r_count <= CNT_W'(INIT_FREE);
    end else begin
      for (int l = 0; l < rn_pkg::DISP_SIZE; l++) begin
        if (i_push[l]) begin
          r_mem[w_push_idx[l]] <= i_push_rnid[l];
        end
      end
      r_head  <= r_head + rn_pkg::RNID_W'(w_pop_cnt);
      r_tail  <= r_tail + rn_pkg::RNID_W'(w_push_cnt);
      r_count <= r_count + w_push_cnt - w_pop_cnt;
    end
  end

  assign o_has_two = (r_count >= CNT_W'(2));

endmodule

`default_nettype wire

/* src/select_latest_1bit.sv */
`default_nettype none
`timescale 1ns/1ns

module select_latest_1bit #(
  parameter int SEL_WIDTH = 2,
  parameter int KEY_WIDTH = 6
) (
  input  logic [KEY_WIDTH-1:0] i_cmp_key,
  input  logic [SEL_WIDTH-1:0] i_valid,
  input  logic [KEY_WIDTH-1:0] i_keys [SEL_WIDTH],
  input  logic [SEL_WIDTH-1:0] i_data,
  output logic                 o_valid,
  output logic                 o_data
);

  // Scan upward so the highest matching index is left standing
  always_comb begin
    o_valid = 1'b0;
    o_data  = 1'b0;
    for (int i = 0; i < SEL_WIDTH; i++) begin
      if (i_valid[i] && (i_keys[i] == i_cmp_key)) begin
        o_valid = 1'b1;
        o_data  = i_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* src/rn_pkg.sv */
`default_nettype none

package rn_pkg;

  // Group and port counts
  localparam int DISP_SIZE = 2;
  localparam int WB_SIZE   = 2;

  // Architectural registers
  localparam int ARCH_W    = 5;
  localparam int ARCH_SIZE = 1 << ARCH_W;

  // Physical rename IDs
  localparam int RNID_SIZE = 64;
  localparam int RNID_W    = 6;

  // Two source lookups per lane
  localparam int LOOKUP_SIZE = DISP_SIZE * 2;

  typedef enum logic {
    GPR,
    FPR
  } reg_kind_t;

endpackage

`default_nettype wire
